// File: vlog.f
+incdir+common
common/dct_sample_pkg.sv
common/dct_coef_pkg.sv
hw/dct_row/dct_butterfly_stage.sv
hw/dct_row/dct_even_part.sv
hw/dct_row/dct_odd_part.sv
hw/dct_row/dct_row_top.sv
tb/dct_row_clk_gen.sv
tb/dct_row_checker.sv
tb/dct_row_assertions.sv
tb/dct_row_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the DCT row testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
mkdir -p build \
    && verilator --binary --timing --assert -f vlog.f --top-module dct_row_tb \
        -Mdir build -o dct_row_sim > build/build.log 2>&1 \
    || { echo "Verilator build failed"; cat build/build.log; exit 1; }
./build/dct_row_sim > build/sim.log 2>&1
cat build/sim.log
grep -qx "TEST OK" build/sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/dct_row_tb.sv
// DCT row testbench with table rows of known DC, random rows and the closing summary
`timescale 1ns/1ps
`default_nettype none

`include "dct_params.svh"

module dct_row_tb;
    import dct_sample_pkg::*;
    import dct_coef_pkg::*;

    localparam int NUM_VEC     = 12;
    localparam int NUM_RANDOM  = 200;
    localparam int DRAIN_LIMIT = 16;

    // Zero, constants, impulses at n = 0, 7, 15, alternating and ramps
    localparam pixel_row_t VEC_ROW [NUM_VEC] = '{
        128'h0000_0000_0000_0000_0000_0000_0000_0000,
        128'h0101_0101_0101_0101_0101_0101_0101_0101,
        128'h6464_6464_6464_6464_6464_6464_6464_6464,
        128'hffff_ffff_ffff_ffff_ffff_ffff_ffff_ffff,
        128'hff00_0000_0000_0000_0000_0000_0000_0000,
        128'h0000_0000_0000_00ff_0000_0000_0000_0000,
        128'h0000_0000_0000_0000_0000_0000_0000_00ff,
        128'h00ff_00ff_00ff_00ff_00ff_00ff_00ff_00ff,
        128'hff00_ff00_ff00_ff00_ff00_ff00_ff00_ff00,
        128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff,
        128'hffee_ddcc_bbaa_9988_7766_5544_3322_1100,
        128'h0010_2030_4050_6070_8090_a0b0_c0d0_e0f0
    };
    // X0 is 16 times the pixel sum divided by 64 and floored
    localparam int VEC_DC [NUM_VEC] = '{0, 4, 400, 1020, 63, 63, 63, 510, 510, 510, 510, 480};

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       out_valid;
    logic       dc_known;
    pixel_row_t in_row;
    coef_row_t  out_row;
    coef_t      expected_dc;
    int         value_errors;
    int         protocol_errors;
    int         pending_rows;
    int         timeout_errors = 0;

    dct_row_clk_gen i_clk (.clk(clk));

    dct_row_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .out_valid (out_valid),
        .out_row   (out_row)
    );

    dct_row_checker i_chk (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_row          (in_row),
        .expected_dc     (expected_dc),
        .dc_known        (dc_known),
        .out_valid       (out_valid),
        .out_row         (out_row),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending_rows    (pending_rows)
    );

    function automatic pixel_row_t random_row();
        pixel_row_t row;
        for (int n = 0; n < `DCT_N; n++) begin
            row[n] = pixel_t'($urandom_range(255, 0));
        end
        return row;
    endfunction

    task automatic send_row(input pixel_row_t row, input coef_t dc, input logic known);
        @(posedge clk);
        in_valid    <= 1'b1;
        in_row      <= row;
        expected_dc <= dc;
        dc_known    <= known;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
        dc_known <= 1'b0;
    endtask

    // Reset for a few cycles while rows are still inside the pipeline
    task automatic reset_in_flight(input int cycles);
        @(posedge clk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        dc_known <= 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;
    endtask

    initial begin
        int gap;
        int waited;
        void'($urandom(32'hbe508acb));
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_row      = '0;
        expected_dc = '0;
        dc_known    = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        // Quiet gap where out_valid must stay low
        for (int i = 0; i < 4; i++) begin
            idle_cycle();
        end
        for (int i = 0; i < NUM_VEC; i++) begin
            send_row(VEC_ROW[i], coef_t'(VEC_DC[i]), 1'b1);
        end
        idle_cycle();
        // First half back to back and second half with idle gaps
        for (int i = 0; i < NUM_RANDOM; i++) begin
            // The last two back-to-back rows are still in flight when reset hits
            if (i == NUM_RANDOM / 2) begin
                reset_in_flight(4);
            end
            send_row(random_row(), '0, 1'b0);
            if (i >= NUM_RANDOM / 2) begin
                gap = int'($urandom_range(3, 0));
                for (int g = 0; g < gap; g++) begin
                    idle_cycle();
                end
            end
        end
        idle_cycle();
        // Drain the pipeline and sample on the falling edge
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (pending_rows != 0 && waited < DRAIN_LIMIT);
        if (pending_rows != 0) begin
            $display("timeout: %0d rows never came out after %0d cycles", pending_rows, waited);
            timeout_errors++;
        end
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/dct_row_assertions.sv
// DCT row assertions: valid-tag latency, known output data and reset clearing on the row top
`timescale 1ns/1ps
`default_nettype none

`include "dct_params.svh"

module dct_row_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    in_valid,
    input logic                    out_valid,
    input dct_coef_pkg::coef_row_t out_row
);
    // Valid tag passes through exactly DCT_LATENCY registers
    a_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, `DCT_LATENCY))
        else $error("out_valid is not in_valid delayed by the pipeline depth");

    // A valid row carries no unknown bits
    a_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_row))
        else $error("out_row holds unknown bits while out_valid is high");

    // Synchronous reset clears the tag by the next edge
    a_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

endmodule

bind dct_row_top dct_row_assertions i_assert (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_row   (out_row)
);

`default_nettype wire

// File: tb/dct_row_checker.sv
// DCT row checker that queues accepted rows, models all coefficients and compares each output row
`timescale 1ns/1ps
`default_nettype none

`include "dct_params.svh"

module dct_row_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  dct_sample_pkg::pixel_row_t in_row,
    input  dct_coef_pkg::coef_t        expected_dc,
    input  logic                       dc_known,
    input  logic                       out_valid,
    input  dct_coef_pkg::coef_row_t    out_row,
    output int                         value_errors,
    output int                         protocol_errors,
    output int                         pending_rows
);
    import dct_sample_pkg::*;
    import dct_coef_pkg::*;

    // Table entries round(16*sqrt(2)*cos(j*pi/32)) for j = 1..15
    // C0 is unused and C16 stands for the cosine zero
    localparam int COS_TAB [17] = '{0, 23, 22, 22, 21, 20, 19, 17, 16, 14, 13, 11, 9, 7, 4, 2, 0};

    // One accepted row with the cycle it was sampled in
    typedef struct packed {
        pixel_row_t  row;
        coef_t       dc;
        logic        known;
        logic [31:0] cycle;
    } entry_t;

    entry_t      exp_q [$];
    logic [31:0] cycle = '0;
    int          value_count = 0;
    int          protocol_count = 0;

    assign value_errors    = value_count;
    assign protocol_errors = protocol_count;

    // Weight of pixel n in X_k
    // Sign follows the quadrant of (2n+1)k*pi/32
    function automatic int weight(input int k, input int n);
        int m;
        int r;
        m = ((2 * n + 1) * k) % 64;
        r = m % 16;
        if (k == 0) begin
            return 16;
        end
        case (m / 16)
            0:       return COS_TAB[r];
            1:       return -COS_TAB[16 - r];
            2:       return -COS_TAB[r];
            default: return COS_TAB[16 - r];
        endcase
    endfunction

    // Weighted sum floored by 64 and wrapped to the coefficient width
    function automatic coef_t model_coef(input pixel_row_t row, input int k);
        int acc;
        int scaled;
        acc = 0;
        for (int n = 0; n < `DCT_N; n++) begin
            acc += int'(row[`DCT_N-1-n]) * weight(k, n);
        end
        scaled = acc >>> `DCT_FRAC_SHIFT;
        return scaled[`DCT_COEF_W-1:0];
    endfunction

    always @(posedge clk) begin
        entry_t ent;
        coef_t  want;
        cycle = cycle + 1;
        // Reset drops every row still inside the pipeline
        if (rst) begin
            exp_q.delete();
        end
        // Pop before push so a row never meets its own output
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("%0t: out_valid high with no accepted row waiting", $time);
                protocol_count++;
            end else begin
                ent = exp_q.pop_front();
                if (cycle - ent.cycle != `DCT_LATENCY) begin
                    $display("%0t: row arrived %0d cycles after its input instead of %0d",
                             $time, cycle - ent.cycle, `DCT_LATENCY);
                    protocol_count++;
                end
                // Hand-derived DC column
                if (ent.known && out_row[`DCT_N-1] !== ent.dc) begin
                    $display("CHECK FAILED time=%0t signal=X0(table) expected=%0d actual=%0d",
                             $time, ent.dc, out_row[`DCT_N-1]);
                    value_count++;
                end
                for (int k = 0; k < `DCT_N; k++) begin
                    want = model_coef(ent.row, k);
                    if (out_row[`DCT_N-1-k] !== want) begin
                        $display("CHECK FAILED time=%0t signal=X%0d expected=%0d actual=%0d",
                                 $time, k, want, out_row[`DCT_N-1-k]);
                        value_count++;
                    end
                end
            end
        end
        if (!rst && in_valid) begin
            ent = '{in_row, expected_dc, dc_known, cycle};
            exp_q.push_back(ent);
        end
        pending_rows = exp_q.size();
    end

endmodule

`default_nettype wire

// File: tb/dct_row_clk_gen.sv
// DCT row clock generator: free-running testbench clock, 8 ns period
`timescale 1ns/1ps
`default_nettype none

module dct_row_clk_gen #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic clk
);
    // Starts low, first rising edge after one half period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: hw/dct_row/dct_row_top.sv
// DCT row top: two-stage pipelined 16-point row transform, one row per clock
`timescale 1ns/1ps
`default_nettype none

`include "dct_params.svh"

module dct_row_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  dct_sample_pkg::pixel_row_t in_row,
    output logic                       out_valid,
    output dct_coef_pkg::coef_row_t    out_row
);
    import dct_sample_pkg::*;
    import dct_coef_pkg::*;

    localparam int HALF = `DCT_N / 2;

    // Stage one output, shared by both halves
    butterfly_t bfly;
    // Stage two outputs
    logic       even_valid;
    half_row_t  even_coefs;
    half_row_t  odd_coefs;

    dct_butterfly_stage i_bfly (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_row   (in_row),
        .bfly     (bfly)
    );

    dct_even_part i_even (
        .clk        (clk),
        .rst        (rst),
        .bfly       (bfly),
        .even_valid (even_valid),
        .even_coefs (even_coefs)
    );

    dct_odd_part i_odd (
        .clk       (clk),
        .bfly      (bfly),
        .odd_coefs (odd_coefs)
    );

    // Odd half shares the even half's timing, so one tag covers the row
    assign out_valid = even_valid;

    // X0, X1, X2 ... X15 from the top slot down
    always_comb begin
        for (int i = 0; i < HALF; i++) begin
            out_row[`DCT_N-1-2*i] = even_coefs[HALF-1-i];
            out_row[`DCT_N-2-2*i] = odd_coefs[HALF-1-i];
        end
    end

endmodule

`default_nettype wire

// File: hw/dct_row/dct_odd_part.sv
// DCT odd part: X1..X15 as shift-add weighted sums of the pair differences, registered
`timescale 1ns/1ps
`default_nettype none

`include "dct_params.svh"

module dct_odd_part (
    input  logic                       clk,
    input  dct_sample_pkg::butterfly_t bfly,
    output dct_coef_pkg::half_row_t    odd_coefs
);
    import dct_coef_pkg::*;

    localparam int HALF = `DCT_N / 2;
    // Angle steps of pi/32 in one full turn
    localparam int TURN = 4 * `DCT_N;

    // Table index of angle m*pi/32 after folding into the first quadrant
    function automatic int fold_index(input int m);
        if (m <= TURN / 4) begin
            return m;
        end else if (m <= TURN / 2) begin
            return TURN / 2 - m;
        end else if (m <= 3 * TURN / 4) begin
            return m - TURN / 2;
        end
        return TURN - m;
    endfunction

    // Cosine is negative in the second and third quadrants
    function automatic bit fold_negative(input int m);
        return (m > TURN / 4) && (m < 3 * TURN / 4);
    endfunction

    // Signed weighted term of pair n for X_(2i+1)
    acc_t term [HALF][HALF];
    // Row sums, slot i holds X_(2i+1)
    acc_t acc [HALF];

    for (genvar i = 0; i < HALF; i++) begin : g_coef
        for (genvar n = 0; n < HALF; n++) begin : g_term
            // Angle index (2n+1)k mod 64 with k = 2i+1
            localparam int M   = ((2 * n + 1) * (2 * i + 1)) % TURN;
            localparam int J   = fold_index(M);
            localparam bit NEG = fold_negative(M);

            if (NEG) begin : g_neg
                assign term[i][n] = -mul_c(J, acc_t'(bfly.diff[n]));
            end else begin : g_pos
                assign term[i][n] = mul_c(J, acc_t'(bfly.diff[n]));
            end
        end
    end

    // Adder trees, one per odd coefficient
    always_comb begin
        for (int i = 0; i < HALF; i++) begin
            acc[i] = '0;
            for (int n = 0; n < HALF; n++) begin
                acc[i] = acc[i] + term[i][n];
            end
        end
    end

    // Data only, timing matches the even half
    always_ff @(posedge clk) begin
        for (int i = 0; i < HALF; i++) begin
            odd_coefs[HALF-1-i] <= scale_down(acc[i]);
        end
    end

endmodule

`default_nettype wire

// File: hw/dct_row/dct_even_part.sv
// DCT even part: X0..X14 from the pair sums through recursive butterflies, registered
`timescale 1ns/1ps
`default_nettype none

`include "dct_params.svh"

module dct_even_part (
    input  logic                       clk,
    input  logic                       rst,
    input  dct_sample_pkg::butterfly_t bfly,
    output logic                       even_valid,
    output dct_coef_pkg::half_row_t    even_coefs
);
    import dct_coef_pkg::*;

    localparam int HALF = `DCT_N / 2;
    localparam int S2_W = `DCT_PIX_W + 2;
    localparam int S3_W = `DCT_PIX_W + 3;
    localparam int S4_W = `DCT_PIX_W + 4;

    // Second butterfly, pair sum n against pair sum 7-n
    logic        [S2_W-1:0] st2_sum  [HALF/2];
    logic signed [S2_W-1:0] st2_diff [HALF/2];
    // Third butterfly, on stage-two sums only
    logic        [S3_W-1:0] st3_sum  [2];
    logic signed [S3_W-1:0] st3_diff [2];
    // Fourth butterfly, feeds DC and X8
    logic        [S4_W-1:0] dc_sum;
    logic signed [S4_W-1:0] dc_diff;

    // Sign-extended copies for the weighted sums
    acc_t bw [HALF/2];
    acc_t fw [2];
    // Accumulators, slot i holds X_(2i)
    acc_t acc [HALF];

    always_comb begin
        for (int n = 0; n < HALF / 2; n++) begin
            st2_sum[n]  = S2_W'(bfly.sum[n]) + S2_W'(bfly.sum[HALF-1-n]);
            st2_diff[n] = $signed(S2_W'(bfly.sum[n])) - $signed(S2_W'(bfly.sum[HALF-1-n]));
        end
        // (0,3) and (1,2) of the 4-point even half
        for (int n = 0; n < 2; n++) begin
            st3_sum[n]  = S3_W'(st2_sum[n]) + S3_W'(st2_sum[3-n]);
            st3_diff[n] = $signed(S3_W'(st2_sum[n])) - $signed(S3_W'(st2_sum[3-n]));
        end
        dc_sum  = S4_W'(st3_sum[0]) + S4_W'(st3_sum[1]);
        dc_diff = $signed(S4_W'(st3_sum[0])) - $signed(S4_W'(st3_sum[1]));
    end

    always_comb begin
        for (int n = 0; n < HALF / 2; n++) begin
            bw[n] = acc_t'(st2_diff[n]);
        end
        for (int n = 0; n < 2; n++) begin
            fw[n] = acc_t'(st3_diff[n]);
        end

        // X0 and X8 carry the flat weight 16
        acc[0] = acc_t'(dc_sum) <<< 4;
        acc[4] = acc_t'(dc_diff) <<< 4;

        // X4 and X12 rotate the third-stage differences by C4/C12
        acc[2] = mul_c(4, fw[0]) + mul_c(12, fw[1]);
        acc[6] = mul_c(12, fw[0]) - mul_c(4, fw[1]);

        // X2, X6, X10, X14 from the second-stage differences
        // Signs follow cos((2n+1)k*pi/32) folded into C2, C6, C10, C14
        acc[1] = mul_c(2, bw[0]) + mul_c(6, bw[1]) + mul_c(10, bw[2]) + mul_c(14, bw[3]);
        acc[3] = mul_c(6, bw[0]) - mul_c(14, bw[1]) - mul_c(2, bw[2]) - mul_c(10, bw[3]);
        acc[5] = mul_c(10, bw[0]) - mul_c(2, bw[1]) + mul_c(14, bw[2]) + mul_c(6, bw[3]);
        acc[7] = mul_c(14, bw[0]) - mul_c(10, bw[1]) + mul_c(6, bw[2]) - mul_c(2, bw[3]);
    end

    // Valid tag follows the butterfly by one edge
    always_ff @(posedge clk) begin
        if (rst) begin
            even_valid <= 1'b0;
        end else begin
            even_valid <= bfly.valid;
        end
    end

    // Scaled coefficients, X0 lands in the top slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < HALF; i++) begin
            even_coefs[HALF-1-i] <= scale_down(acc[i]);
        end
    end

endmodule

`default_nettype wire

// File: hw/dct_row/dct_butterfly_stage.sv
// DCT butterfly stage: sums and differences of mirrored pixel pairs, registered once
`timescale 1ns/1ps
`default_nettype none

`include "dct_params.svh"

module dct_butterfly_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  dct_sample_pkg::pixel_row_t in_row,
    output dct_sample_pkg::butterfly_t bfly
);
    import dct_sample_pkg::*;

    localparam int HALF = `DCT_N / 2;

    // Pixel n and its mirror DCT_N-1-n
    pixel_t near_pix [HALF];
    pixel_t far_pix  [HALF];

    // Undo the MSB-first packing of the row
    always_comb begin
        for (int n = 0; n < HALF; n++) begin
            near_pix[n] = in_row[`DCT_N-1-n];
            far_pix[n]  = in_row[n];
        end
    end

    always_ff @(posedge clk) begin
        // Pair sums and differences, no growth beyond one bit
        for (int n = 0; n < HALF; n++) begin
            bfly.sum[n]  <= pair_sum_t'(near_pix[n]) + pair_sum_t'(far_pix[n]);
            bfly.diff[n] <= pair_diff_t'(near_pix[n]) - pair_diff_t'(far_pix[n]);
        end
        // Only the tag is cleared, payload follows the row
        if (rst) begin
            bfly.valid <= 1'b0;
        end else begin
            bfly.valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

// File: common/dct_coef_pkg.sv
// DCT coefficient package: coefficient types, accumulator width and shift-add cosine weights
`default_nettype none

`include "dct_params.svh"

package dct_coef_pkg;

    // Accumulator width, worst case is the DC term 16*16*255 plus sign
    localparam int ACC_W = 20;

    // One signed output coefficient
    typedef logic signed [`DCT_COEF_W-1:0] coef_t;

    // Full output row, X_k in slot DCT_N-1-k so X0 is most significant
    typedef coef_t [`DCT_N-1:0] coef_row_t;

    // One parity half, X_(2i) or X_(2i+1) in slot DCT_N/2-1-i
    typedef coef_t [`DCT_N/2-1:0] half_row_t;

    // Weighted sums before the final scaling
    typedef logic signed [ACC_W-1:0] acc_t;

    // Multiply by C_j = round(16*sqrt(2)*cos(j*pi/32)) with shifts and adds only
    function automatic acc_t mul_c(input int unsigned j, input acc_t v);
        acc_t r;
        case (j)
            1:       r = (v <<< 4) + (v <<< 2) + (v <<< 1) + v;  // 23
            2, 3:    r = (v <<< 4) + (v <<< 2) + (v <<< 1);      // 22
            4:       r = (v <<< 4) + (v <<< 2) + v;              // 21
            5:       r = (v <<< 4) + (v <<< 2);                  // 20
            6:       r = (v <<< 4) + (v <<< 1) + v;              // 19
            7:       r = (v <<< 4) + v;                          // 17
            8:       r = v <<< 4;                                // 16
            9:       r = (v <<< 3) + (v <<< 2) + (v <<< 1);      // 14
            10:      r = (v <<< 3) + (v <<< 2) + v;              // 13
            11:      r = (v <<< 3) + (v <<< 1) + v;              // 11
            12:      r = (v <<< 3) + v;                          // 9
            13:      r = (v <<< 2) + (v <<< 1) + v;              // 7
            14:      r = v <<< 2;                                // 4
            15:      r = v <<< 1;                                // 2
            default: r = '0;
        endcase
        return r;
    endfunction

    // Floor divide by 2^FRAC_SHIFT, wrap to coefficient width
    function automatic coef_t scale_down(input acc_t acc);
        return acc[`DCT_FRAC_SHIFT +: `DCT_COEF_W];
    endfunction

endpackage

`default_nettype wire

// File: common/dct_sample_pkg.sv
// DCT sample package: pixel-side types from the input row through the first butterfly
`default_nettype none

`include "dct_params.svh"

package dct_sample_pkg;

    // One unsigned pixel
    typedef logic [`DCT_PIX_W-1:0] pixel_t;

    // Full input row
    // Pixel n sits in slot DCT_N-1-n, so pixel 0 is the most significant byte
    typedef pixel_t [`DCT_N-1:0] pixel_row_t;

    // Sum of a mirrored pair, one bit of growth
    typedef logic [`DCT_PIX_W:0] pair_sum_t;

    // Difference of a mirrored pair, pixel n minus pixel DCT_N-1-n
    typedef logic signed [`DCT_PIX_W:0] pair_diff_t;

    // Registered first-stage butterfly
    // Slot n of sum and diff belongs to the pair (n, DCT_N-1-n)
    typedef struct packed {
        logic                              valid;
        pair_sum_t  [`DCT_N/2-1:0]         sum;
        pair_diff_t [`DCT_N/2-1:0]         diff;
    } butterfly_t;

endpackage

`default_nettype wire

// File: common/dct_params.svh
// DCT row parameters: sizes of the 16-point row transform and its pipeline depth
`ifndef DCT_PARAMS_SVH
`define DCT_PARAMS_SVH

// Points per row
`define DCT_N 16

// Unsigned pixel width
`define DCT_PIX_W 8

// Signed output coefficient width
`define DCT_COEF_W 12

// Fraction bits dropped from every accumulator, i.e. divide by 64
`define DCT_FRAC_SHIFT 6

// Clock edges from an accepted row to its coefficients
`define DCT_LATENCY 2

`endif
